//--- Makefile
# Verilator build for the VGA text overlay testbench

VERILATOR  ?= verilator
TOP        := tb_vga_text
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- common/vga_defines.svh
// VGA 800x600 timing constants, text box geometry
// and the display colour set

`ifndef VGA_DEFINES_SVH
`define VGA_DEFINES_SVH

`define VGA_H_ACTIVE     11'd800
`define VGA_H_TOTAL      11'd1056
`define VGA_H_SYNC_START 11'd840
`define VGA_H_SYNC_END   11'd968

`define VGA_V_ACTIVE     11'd600
`define VGA_V_TOTAL      11'd628
`define VGA_V_SYNC_START 11'd601
`define VGA_V_SYNC_END   11'd605

`define TEXT_POS_X  11'd128
`define TEXT_POS_Y  11'd128
`define TEXT_WIDTH  11'd256
`define TEXT_HEIGHT 11'd128
`define TEXT_SCALE  2             // glyph pixel is 4x4 screen pixels

`define COLOR_BG     12'h00f      // blue
`define COLOR_BORDER 12'hf00      // red
`define COLOR_TEXT   12'hfff      // white

`endif

//--- common/vga_pkg.sv
// vga_pkg with vector types for counters, colour,
// character addressing and glyph rows

`default_nettype none

package vga_pkg;

    typedef logic [10:0] count_t;       // pixel counter
    typedef logic [11:0] rgb_t;         // 4 bits per channel

    // column in [7:3], row in [2:0]
    typedef logic [7:0] char_xy_t;

    typedef logic [3:0] char_line_t;    // glyph row within a character
    typedef logic [6:0] char_code_t;

    // msb is the leftmost pixel
    typedef logic [7:0] glyph_row_t;

endpackage

`default_nettype wire

//--- dv/tb_vga_text.sv
// tb_vga_text: directed testbench for vga_text_top with a
// reference pixel model, frame scans and a watchdog

`timescale 1ns/100ps
`default_nettype none

`include "vga_defines.svh"

module tb_vga_text;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int H_ACTIVE     = int'(`VGA_H_ACTIVE);
    localparam int H_TOTAL      = int'(`VGA_H_TOTAL);
    localparam int H_SYNC_START = int'(`VGA_H_SYNC_START);
    localparam int H_SYNC_END   = int'(`VGA_H_SYNC_END);
    localparam int V_ACTIVE     = int'(`VGA_V_ACTIVE);
    localparam int V_TOTAL      = int'(`VGA_V_TOTAL);
    localparam int V_SYNC_START = int'(`VGA_V_SYNC_START);
    localparam int V_SYNC_END   = int'(`VGA_V_SYNC_END);
    localparam int BOX_X        = int'(`TEXT_POS_X);
    localparam int BOX_Y        = int'(`TEXT_POS_Y);
    localparam int BOX_W        = int'(`TEXT_WIDTH);
    localparam int BOX_H        = int'(`TEXT_HEIGHT);
    localparam int SCALE        = `TEXT_SCALE;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    // one frame to find the frame edge, two scanned frames, plus slack
    localparam int TIMEOUT_NS   = (3 * FRAME_CYCLES + 10000) * CLK_PERIOD;

    logic            clk;
    logic            rst;
    logic            start_game;
    vga_pkg::count_t hcount;
    vga_pkg::count_t vcount;
    logic            hsync;
    logic            vsync;
    logic            hblnk;
    logic            vblnk;
    vga_pkg::rgb_t   rgb;

    int prev_h;                                   // last sampled position
    int prev_v;

    vga_text_top dut (
        .clk        (clk),
        .rst        (rst),
        .start_game (start_game),
        .hcount     (hcount),
        .vcount     (vcount),
        .hsync      (hsync),
        .vsync      (vsync),
        .hblnk      (hblnk),
        .vblnk      (vblnk),
        .rgb        (rgb)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s at h=%0d v=%0d: got 0x%0h expected 0x%0h",
                     name, prev_h, prev_v, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "output check failed");
        end
    endtask

    function automatic logic [6:0] code_at(input int col, input int row);
        int addr;
        addr = col * 8 + row;                     // column above row bits
        return 7'(32'h20 + (addr % 128));
    endfunction

    function automatic logic [7:0] glyph_for(input logic [6:0] code, input int line);
        logic [7:0] row;
        row = {1'b0, code};
        for (int i = 0; i < line % 8; i++) begin
            row = {row[6:0], row[7]};
        end
        if (line == 0) begin
            row[7] = 1'b1;                        // top line marker
        end
        return row;
    endfunction

    function automatic bit inside_text_box(input int h, input int v);
        return (h >= BOX_X) && (h < BOX_X + BOX_W) && (v >= BOX_Y) && (v < BOX_Y + BOX_H);
    endfunction

    function automatic vga_pkg::rgb_t pixel_prediction(input int h, input int v, input bit game);
        int         gx;
        int         gy;
        logic [7:0] glyph;
        if (h >= H_ACTIVE || v >= V_ACTIVE) begin
            return 12'h000;
        end
        if (inside_text_box(h, v) && !game) begin
            gx    = (h - BOX_X) >> SCALE;         // glyph pixel coordinates
            gy    = (v - BOX_Y) >> SCALE;
            glyph = glyph_for(code_at(gx / 8, gy / 16), gy % 16);
            if (glyph[3'(7 - gx % 8)]) begin
                return `COLOR_TEXT;
            end
        end
        if (v == 0 || v == V_ACTIVE - 1 || h == 0 || h == H_ACTIVE - 1) begin
            return `COLOR_BORDER;
        end
        return `COLOR_BG;
    endfunction

    task automatic outputs_all_zero();
        check_value("hcount", 32'(hcount), 32'd0);
        check_value("vcount", 32'(vcount), 32'd0);
        check_value("hsync", 32'(hsync), 32'd0);
        check_value("vsync", 32'(vsync), 32'd0);
        check_value("hblnk", 32'(hblnk), 32'd0);
        check_value("vblnk", 32'(vblnk), 32'd0);
        check_value("rgb", 32'(rgb), 32'd0);
    endtask

    // reset for 5 cycles, then one cycle of flushed zeros
    task automatic reset_and_check_zeros();
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i == RESET_CYCLES - 1) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            outputs_all_zero();
        end
        @(negedge clk);
        outputs_all_zero();
    endtask

    task automatic wait_frame_end();
        do begin
            @(negedge clk);
        end while (!(int'(hcount) == H_TOTAL - 1 && int'(vcount) == V_TOTAL - 1));
        prev_h = H_TOTAL - 1;
        prev_v = V_TOTAL - 1;
    endtask

    task automatic compare_pixel(input bit game);
        int   h;
        int   v;
        logic hs;
        logic vs;
        @(negedge clk);
        h = (prev_h == H_TOTAL - 1) ? 0 : prev_h + 1;
        v = prev_v;
        if (prev_h == H_TOTAL - 1) begin
            v = (prev_v == V_TOTAL - 1) ? 0 : prev_v + 1;   // step at line wrap
        end
        prev_h = h;
        prev_v = v;
        hs = (h >= H_SYNC_START) && (h < H_SYNC_END);
        vs = (v >= V_SYNC_START) && (v < V_SYNC_END);
        check_value("hcount", 32'(hcount), 32'(h));
        check_value("vcount", 32'(vcount), 32'(v));
        check_value("hsync", 32'(hsync), 32'(hs));
        check_value("vsync", 32'(vsync), 32'(vs));
        check_value("hblnk", 32'(hblnk), 32'(h >= H_ACTIVE));
        check_value("vblnk", 32'(vblnk), 32'(v >= V_ACTIVE));
        if (hblnk || vblnk) begin
            check_value("rgb in blanking", 32'(rgb), 32'd0);
        end
        if (game && inside_text_box(h, v)) begin
            check_value("rgb in hidden box", 32'(rgb), 32'(`COLOR_BG));
        end
        check_value("rgb", 32'(rgb), 32'(pixel_prediction(h, v, game)));
    endtask

    task automatic scan_frame(input bit game);
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            compare_pixel(game);
        end
    endtask

    task automatic scan_text_frame();
        scan_frame(1'b0);
    endtask

    // raised at the frame edge, box is far from it
    task automatic hide_text_and_scan();
        @(posedge clk);
        start_game <= 1'b1;
        scan_frame(1'b1);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the frame scans did not finish in the expected time");
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        start_game = 1'b0;
        prev_h     = 0;
        prev_v     = 0;
        reset_and_check_zeros();
        wait_frame_end();
        scan_text_frame();
        hide_text_and_scan();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/draw_bg.sv
// draw_bg: background colour with a one pixel border,
// one register stage on the VGA signals

`timescale 1ns/100ps
`default_nettype none

`include "vga_defines.svh"

module draw_bg (
    input  logic            clk,
    input  logic            rst,
    input  vga_pkg::count_t in_hcount,
    input  vga_pkg::count_t in_vcount,
    input  logic            in_hsync,
    input  logic            in_vsync,
    input  logic            in_hblnk,
    input  logic            in_vblnk,
    output vga_pkg::count_t out_hcount,
    output vga_pkg::count_t out_vcount,
    output logic            out_hsync,
    output logic            out_vsync,
    output logic            out_hblnk,
    output logic            out_vblnk,
    output vga_pkg::rgb_t   out_rgb
);

    vga_pkg::rgb_t rgb_nxt;
    logic          on_border;

    always_comb begin
        on_border = (in_vcount == '0) || (in_vcount == `VGA_V_ACTIVE - 11'd1) ||
                    (in_hcount == '0) || (in_hcount == `VGA_H_ACTIVE - 11'd1);
        if (in_hblnk || in_vblnk) begin
            rgb_nxt = '0;
        end else if (on_border) begin
            rgb_nxt = `COLOR_BORDER;
        end else begin
            rgb_nxt = `COLOR_BG;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_hcount <= '0;
            out_vcount <= '0;
            out_hsync  <= 1'b0;
            out_vsync  <= 1'b0;
            out_hblnk  <= 1'b0;
            out_vblnk  <= 1'b0;
            out_rgb    <= '0;
        end else begin
            out_hcount <= in_hcount;
            out_vcount <= in_vcount;
            out_hsync  <= in_hsync;
            out_vsync  <= in_vsync;
            out_hblnk  <= in_hblnk;
            out_vblnk  <= in_vblnk;
            out_rgb    <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

//--- rtl/vga_text_top.sv
// vga_text_top: timing generator, background, text overlay
// and the screen and font memories

`timescale 1ns/100ps
`default_nettype none

module vga_text_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            start_game,
    output vga_pkg::count_t hcount,
    output vga_pkg::count_t vcount,
    output logic            hsync,
    output logic            vsync,
    output logic            hblnk,
    output logic            vblnk,
    output vga_pkg::rgb_t   rgb
);

    vga_pkg::count_t     tim_hcount;
    vga_pkg::count_t     tim_vcount;
    logic                tim_hsync;
    logic                tim_vsync;
    logic                tim_hblnk;
    logic                tim_vblnk;

    vga_pkg::count_t     bg_hcount;
    vga_pkg::count_t     bg_vcount;
    logic                bg_hsync;
    logic                bg_vsync;
    logic                bg_hblnk;
    logic                bg_vblnk;
    vga_pkg::rgb_t       bg_rgb;

    vga_pkg::char_xy_t   char_xy;
    vga_pkg::char_line_t char_line;
    vga_pkg::char_code_t char_code;
    vga_pkg::glyph_row_t char_line_pixels;

    vga_timing u_timing (
        .clk    (clk),
        .rst    (rst),
        .hcount (tim_hcount),
        .vcount (tim_vcount),
        .hsync  (tim_hsync),
        .vsync  (tim_vsync),
        .hblnk  (tim_hblnk),
        .vblnk  (tim_vblnk)
    );

    draw_bg u_bg (
        .clk        (clk),
        .rst        (rst),
        .in_hcount  (tim_hcount),
        .in_vcount  (tim_vcount),
        .in_hsync   (tim_hsync),
        .in_vsync   (tim_vsync),
        .in_hblnk   (tim_hblnk),
        .in_vblnk   (tim_vblnk),
        .out_hcount (bg_hcount),
        .out_vcount (bg_vcount),
        .out_hsync  (bg_hsync),
        .out_vsync  (bg_vsync),
        .out_hblnk  (bg_hblnk),
        .out_vblnk  (bg_vblnk),
        .out_rgb    (bg_rgb)
    );

    draw_rect_char u_rect_char (
        .clk              (clk),
        .rst              (rst),
        .start_game       (start_game),
        .char_line_pixels (char_line_pixels),
        .in_hcount        (bg_hcount),
        .in_vcount        (bg_vcount),
        .in_hsync         (bg_hsync),
        .in_vsync         (bg_vsync),
        .in_hblnk         (bg_hblnk),
        .in_vblnk         (bg_vblnk),
        .in_rgb           (bg_rgb),
        .char_xy          (char_xy),
        .char_line        (char_line),
        .out_hcount       (hcount),
        .out_vcount       (vcount),
        .out_hsync        (hsync),
        .out_vsync        (vsync),
        .out_hblnk        (hblnk),
        .out_vblnk        (vblnk),
        .out_rgb          (rgb)
    );

    char_rom u_char_rom (
        .clk       (clk),
        .char_xy   (char_xy),
        .char_code (char_code)
    );

    font_rom u_font_rom (
        .clk              (clk),
        .char_code        (char_code),
        .char_line        (char_line),
        .char_line_pixels (char_line_pixels)
    );

endmodule

`default_nettype wire

//--- rtl/vga_timing.sv
// vga_timing: 800x600 horizontal and vertical counters
// with registered sync and blanking outputs

`timescale 1ns/100ps
`default_nettype none

`include "vga_defines.svh"

module vga_timing (
    input  logic            clk,
    input  logic            rst,
    output vga_pkg::count_t hcount,
    output vga_pkg::count_t vcount,
    output logic            hsync,
    output logic            vsync,
    output logic            hblnk,
    output logic            vblnk
);

    vga_pkg::count_t hcount_nxt;
    vga_pkg::count_t vcount_nxt;

    always_comb begin
        hcount_nxt = hcount + 11'd1;
        vcount_nxt = vcount;
        if (hcount == `VGA_H_TOTAL - 11'd1) begin
            hcount_nxt = '0;
            if (vcount == `VGA_V_TOTAL - 11'd1) begin
                vcount_nxt = '0;              // end of frame
            end else begin
                vcount_nxt = vcount + 11'd1;
            end
        end
    end

    // decode from the next count so syncs stay aligned with the counters
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
        end else begin
            hcount <= hcount_nxt;
            vcount <= vcount_nxt;
            hsync  <= (hcount_nxt >= `VGA_H_SYNC_START) && (hcount_nxt < `VGA_H_SYNC_END);
            vsync  <= (vcount_nxt >= `VGA_V_SYNC_START) && (vcount_nxt < `VGA_V_SYNC_END);
            hblnk  <= (hcount_nxt >= `VGA_H_ACTIVE);
            vblnk  <= (vcount_nxt >= `VGA_V_ACTIVE);
        end
    end

    a_hcount_range : assert property (
        @(posedge clk) disable iff (rst)
        hcount < `VGA_H_TOTAL
    );

endmodule

`default_nettype wire

//--- text/char_rom.sv
// char_rom: screen memory of character codes,
// one code per cell, synchronous read

`timescale 1ns/100ps
`default_nettype none

module char_rom (
    input  logic                clk,
    input  vga_pkg::char_xy_t   char_xy,
    output vga_pkg::char_code_t char_code
);

    vga_pkg::char_code_t mem [0:255];

    // printable codes from the space character upward
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 7'h20 + 7'(i);
        end
    end

    always_ff @(posedge clk) begin
        char_code <= mem[char_xy];
    end

endmodule

`default_nettype wire

//--- text/draw_rect_char.sv
// draw_rect_char: scaled text box overlay driven by the
// screen and font memories, 4 cycles from input to output

`timescale 1ns/100ps
`default_nettype none

`include "vga_defines.svh"

module draw_rect_char (
    input  logic                clk,
    input  logic                rst,
    input  logic                start_game,
    input  vga_pkg::glyph_row_t char_line_pixels,
    input  vga_pkg::count_t     in_hcount,
    input  vga_pkg::count_t     in_vcount,
    input  logic                in_hsync,
    input  logic                in_vsync,
    input  logic                in_hblnk,
    input  logic                in_vblnk,
    input  vga_pkg::rgb_t       in_rgb,
    output vga_pkg::char_xy_t   char_xy,
    output vga_pkg::char_line_t char_line,
    output vga_pkg::count_t     out_hcount,
    output vga_pkg::count_t     out_vcount,
    output logic                out_hsync,
    output logic                out_vsync,
    output logic                out_hblnk,
    output logic                out_vblnk,
    output vga_pkg::rgb_t       out_rgb
);

    // three stage delay line, index 2 lines up with the glyph row
    vga_pkg::count_t     hcount_q [0:2];
    vga_pkg::count_t     vcount_q [0:2];
    vga_pkg::rgb_t       rgb_q    [0:2];
    logic [2:0]          hsync_q;
    logic [2:0]          vsync_q;
    logic [2:0]          hblnk_q;
    logic [2:0]          vblnk_q;
    vga_pkg::char_line_t char_line_q;

    vga_pkg::count_t     x_in;
    vga_pkg::count_t     y_in;
    vga_pkg::count_t     x_off;
    logic                in_box;
    logic                glyph_bit;
    vga_pkg::rgb_t       rgb_nxt;

    assign x_in = in_hcount - `TEXT_POS_X;
    assign y_in = in_vcount - `TEXT_POS_Y;

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount_q    <= '{default: '0};
            vcount_q    <= '{default: '0};
            rgb_q       <= '{default: '0};
            hsync_q     <= '0;
            vsync_q     <= '0;
            hblnk_q     <= '0;
            vblnk_q     <= '0;
            char_xy     <= '0;
            char_line_q <= '0;
            char_line   <= '0;
        end else begin
            hcount_q    <= '{in_hcount, hcount_q[0], hcount_q[1]};
            vcount_q    <= '{in_vcount, vcount_q[0], vcount_q[1]};
            rgb_q       <= '{in_rgb, rgb_q[0], rgb_q[1]};
            hsync_q     <= {hsync_q[1:0], in_hsync};
            vsync_q     <= {vsync_q[1:0], in_vsync};
            hblnk_q     <= {hblnk_q[1:0], in_hblnk};
            vblnk_q     <= {vblnk_q[1:0], in_vblnk};
            char_xy     <= {5'(x_in >> (3 + `TEXT_SCALE)), 3'(y_in >> (4 + `TEXT_SCALE))};
            char_line_q <= 4'(y_in >> `TEXT_SCALE);
            char_line   <= char_line_q;           // meets char_code at the font rom
        end
    end

    always_comb begin
        x_off     = hcount_q[2] - `TEXT_POS_X;
        in_box    = (hcount_q[2] >= `TEXT_POS_X) && (hcount_q[2] < `TEXT_POS_X + `TEXT_WIDTH) &&
                    (vcount_q[2] >= `TEXT_POS_Y) && (vcount_q[2] < `TEXT_POS_Y + `TEXT_HEIGHT);
        glyph_bit = char_line_pixels[3'd7 - 3'(x_off >> `TEXT_SCALE)];
        if (in_box && glyph_bit && !start_game) begin
            rgb_nxt = `COLOR_TEXT;
        end else begin
            rgb_nxt = rgb_q[2];                   // background shows through
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_hcount <= '0;
            out_vcount <= '0;
            out_hsync  <= 1'b0;
            out_vsync  <= 1'b0;
            out_hblnk  <= 1'b0;
            out_vblnk  <= 1'b0;
            out_rgb    <= '0;
        end else begin
            out_hcount <= hcount_q[2];
            out_vcount <= vcount_q[2];
            out_hsync  <= hsync_q[2];
            out_vsync  <= vsync_q[2];
            out_hblnk  <= hblnk_q[2];
            out_vblnk  <= vblnk_q[2];
            out_rgb    <= rgb_nxt;
        end
    end

    a_blank_black : assert property (
        @(posedge clk) disable iff (rst)
        (out_hblnk || out_vblnk) |-> (out_rgb == '0)
    );

endmodule

`default_nettype wire

//--- text/font_rom.sv
// font_rom: glyph rows addressed by character code
// and glyph line, synchronous read

`timescale 1ns/100ps
`default_nettype none

module font_rom (
    input  logic                clk,
    input  vga_pkg::char_code_t char_code,
    input  vga_pkg::char_line_t char_line,
    output vga_pkg::glyph_row_t char_line_pixels
);

    vga_pkg::glyph_row_t mem [0:2047];

    // code rotated left by line mod 8, top line marked by bit 7
    function automatic vga_pkg::glyph_row_t glyph_of(input vga_pkg::char_code_t code,
                                                     input vga_pkg::char_line_t line);
        logic [7:0] row;
        logic [2:0] rot;
        row = {1'b0, code};
        rot = line[2:0];
        row = (row << rot) | (row >> (4'd8 - {1'b0, rot}));
        if (line == '0) begin
            row[7] = 1'b1;
        end
        return row;
    endfunction

    initial begin
        for (int a = 0; a < 2048; a++) begin
            mem[a] = glyph_of(7'(a >> 4), 4'(a));
        end
    end

    always_ff @(posedge clk) begin
        char_line_pixels <= mem[{char_code, char_line}];
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+common
common/vga_pkg.sv
rtl/vga_timing.sv
rtl/draw_bg.sv
text/char_rom.sv
text/font_rom.sv
text/draw_rect_char.sv
rtl/vga_text_top.sv
dv/tb_vga_text.sv
